// ==== src/rs5_lite_pkg.sv ====
// Shared constants, instruction views and pipeline structs for the RS5 lite core, compiled first
package rs5_lite_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // Major opcodes kept by the core
    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
    localparam logic [6:0] OPCODE_LOAD   = 7'b0000011;
    localparam logic [6:0] OPCODE_STORE  = 7'b0100011;

    localparam logic [3:0] WORD_STROBE = 4'b1111; // All byte lanes for SW

    ////////////////////////////////////////
    // Instruction word views
    ////////////////////////////////////////

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0]           imm;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0]            imm_hi;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_lo;
        logic [6:0]            opcode;
    } s_type_t;

    typedef struct packed {
        logic [19:0]           imm;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } u_type_t;

    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
        u_type_t u;
    } instr_u;

    ////////////////////////////////////////
    // Operations, lanes and stage payloads
    ////////////////////////////////////////

    typedef enum logic [4:0] {
        OP_NOP, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_LUI,
        OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU, OP_LW, OP_SW
    } op_e;

    typedef enum logic [1:0] {
        LANE_ALU   = 2'd0,
        LANE_SHIFT = 2'd1,
        LANE_LSU   = 2'd2
    } lane_e;

    typedef struct packed {
        op_e                   op;
        logic [REG_ADDR_W-1:0] rd;
        logic                  write_enable;
        logic [XLEN-1:0]       operand_a;
        logic [XLEN-1:0]       operand_b;
        logic [XLEN-1:0]       store_data;
    } exec_req_t;

    typedef struct packed {
        logic                  valid;
        logic                  write_enable;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       result;
        logic                  mem_read;
        logic [3:0]            mem_strobe;
        logic [XLEN-1:0]       mem_address;
        logic [XLEN-1:0]       mem_write_data;
    } lane_out_t;

endpackage

// ==== src/fetch_unit.sv ====
// Fetch stage: program counter and instruction register feeding the decoder
`timescale 1ns/100ps

module fetch_unit #(
    parameter logic [rs5_lite_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                          clk,
    input  logic                          rst_i,
    input  logic                          enable_i,
    input  logic [rs5_lite_pkg::XLEN-1:0] instruction_i,
    output logic [rs5_lite_pkg::XLEN-1:0] instruction_address_o,
    output logic [rs5_lite_pkg::XLEN-1:0] instruction_o
);
    import rs5_lite_pkg::*;

    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013; // addi x0, x0, 0

    logic [XLEN-1:0] pc;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc            <= RESET_PC;
            instruction_o <= NOP_INSTR; // Decode sees a harmless word
        end else if (enable_i) begin
            pc            <= pc + 32'd4;
            instruction_o <= instruction_i; // Word returned for current pc
        end
    end

    assign instruction_address_o = pc;

endmodule

// ==== src/decode_unit.sv ====
// Decode stage: field decode, operand read, lane choice and the one-bubble RAW stall
`timescale 1ns/100ps

module decode_unit (
    input  logic                                clk,
    input  logic                                rst_i,
    input  logic                                stall_i,
    input  logic [rs5_lite_pkg::XLEN-1:0]       instruction_i,
    input  logic [rs5_lite_pkg::XLEN-1:0]       rs1_data_i,
    input  logic [rs5_lite_pkg::XLEN-1:0]       rs2_data_i,
    output logic [rs5_lite_pkg::REG_ADDR_W-1:0] rs1_o,
    output logic [rs5_lite_pkg::REG_ADDR_W-1:0] rs2_o,
    output logic                                fetch_enable_o,
    output logic [2:0]                          lane_sel_o,
    output rs5_lite_pkg::exec_req_t             req_o
);
    import rs5_lite_pkg::*;

    instr_u    word;
    exec_req_t next_req;
    lane_e     lane;
    logic      use_rs1;
    logic      use_rs2;
    logic      hazard;
    logic [2:0] next_sel;

    assign word  = instruction_i;
    assign rs1_o = word.r.rs1;
    assign rs2_o = word.r.rs2;

    always_comb begin
        next_req            = '0;
        next_req.rd         = word.r.rd;
        next_req.operand_a  = rs1_data_i;
        next_req.operand_b  = rs2_data_i;
        next_req.store_data = rs2_data_i;
        use_rs1             = 1'b0;
        use_rs2             = 1'b0;
        case (word.r.opcode)
            OPCODE_OP, OPCODE_OP_IMM: begin
                use_rs1 = 1'b1;
                use_rs2 = (word.r.opcode == OPCODE_OP);
                if (word.r.opcode == OPCODE_OP_IMM) begin
                    next_req.operand_b = {{20{word.i.imm[11]}}, word.i.imm};
                end
                case (word.r.funct3)
                    3'b000: next_req.op = (use_rs2 && word.r.funct7[5]) ? OP_SUB : OP_ADD;
                    3'b001: next_req.op = OP_SLL;
                    3'b010: next_req.op = OP_SLT;
                    3'b011: next_req.op = OP_SLTU;
                    3'b100: next_req.op = OP_XOR;
                    3'b101: next_req.op = word.r.funct7[5] ? OP_SRA : OP_SRL; // Bit 30 in both forms
                    3'b110: next_req.op = OP_OR;
                    default: next_req.op = OP_AND;
                endcase
            end
            OPCODE_LUI: begin
                next_req.op        = OP_LUI;
                next_req.operand_b = {word.u.imm, 12'b0};
            end
            OPCODE_LOAD: begin
                use_rs1            = 1'b1;
                next_req.op        = (word.i.funct3 == 3'b010) ? OP_LW : OP_NOP; // Word only
                next_req.operand_b = {{20{word.i.imm[11]}}, word.i.imm};
            end
            OPCODE_STORE: begin
                use_rs1            = 1'b1;
                use_rs2            = 1'b1;
                next_req.op        = (word.s.funct3 == 3'b010) ? OP_SW : OP_NOP;
                next_req.operand_b = {{20{word.s.imm_hi[6]}}, word.s.imm_hi, word.s.imm_lo};
            end
            default: next_req.op = OP_NOP; // Anything else is a bubble
        endcase
        next_req.write_enable = (next_req.op != OP_NOP) && (next_req.op != OP_SW);
    end

    // Lane claim for the decoded op
    always_comb begin
        case (next_req.op)
            OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU: lane = LANE_SHIFT;
            OP_LW, OP_SW:                           lane = LANE_LSU;
            default:                                lane = LANE_ALU;
        endcase
        next_sel = (next_req.op == OP_NOP) ? 3'b000 : (3'b001 << lane);
    end

    // Producer still in execute, so its value is not yet in the bank
    assign hazard = req_o.write_enable && (req_o.rd != '0) &&
                    ((use_rs1 && word.r.rs1 == req_o.rd) ||
                     (use_rs2 && word.r.rs2 == req_o.rd));

    assign fetch_enable_o = !stall_i && !hazard;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            req_o      <= '0;
            lane_sel_o <= '0;
        end else if (!stall_i) begin
            req_o      <= hazard ? '0 : next_req; // Bubble while fetch holds
            lane_sel_o <= hazard ? '0 : next_sel;
        end
    end

    // A bubble never claims a lane and never writes a register
    assert property (@(posedge clk) disable iff (rst_i)
        $onehot0(lane_sel_o) && (lane_sel_o != '0 || !req_o.write_enable))
        else $error("decode issued a malformed lane claim");

endmodule

// ==== src/register_bank.sv ====
// Integer register file: x1..x31 with two read ports and write-through on a same-cycle write
`timescale 1ns/100ps

module register_bank (
    input  logic                                clk,
    input  logic [rs5_lite_pkg::REG_ADDR_W-1:0] rs1_i,
    input  logic [rs5_lite_pkg::REG_ADDR_W-1:0] rs2_i,
    input  logic                                we_i,
    input  logic [rs5_lite_pkg::REG_ADDR_W-1:0] rd_i,
    input  logic [rs5_lite_pkg::XLEN-1:0]       data_i,
    output logic [rs5_lite_pkg::XLEN-1:0]       data1_o,
    output logic [rs5_lite_pkg::XLEN-1:0]       data2_o
);
    import rs5_lite_pkg::*;

    logic [XLEN-1:0] regs [1:31];

    function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] idx);
        if (idx == '0) begin
            return '0; // x0 is hardwired
        end else if (we_i && rd_i == idx) begin
            return data_i; // Bypass the write in flight
        end
        return regs[idx];
    endfunction

    always_ff @(posedge clk) begin
        if (we_i && rd_i != '0) begin
            regs[rd_i] <= data_i;
        end
    end

    always_comb begin
        data1_o = read_port(rs1_i);
        data2_o = read_port(rs2_i);
    end

endmodule

// ==== src/execute_alu.sv ====
// Execute lane for add, sub, logic ops and LUI, registered into the retire stage
`timescale 1ns/100ps

module execute_alu (
    input  logic                    clk,
    input  logic                    rst_i,
    input  logic                    stall_i,
    input  logic                    valid_i,
    input  rs5_lite_pkg::exec_req_t req_i,
    output rs5_lite_pkg::lane_out_t out_o
);
    import rs5_lite_pkg::*;

    lane_out_t next;

    always_comb begin
        next              = '0;
        next.valid        = valid_i;
        next.write_enable = valid_i && req_i.write_enable;
        next.rd           = req_i.rd;
        case (req_i.op)
            OP_ADD:  next.result = req_i.operand_a + req_i.operand_b;
            OP_SUB:  next.result = req_i.operand_a - req_i.operand_b;
            OP_AND:  next.result = req_i.operand_a & req_i.operand_b;
            OP_OR:   next.result = req_i.operand_a | req_i.operand_b;
            OP_XOR:  next.result = req_i.operand_a ^ req_i.operand_b;
            OP_LUI:  next.result = req_i.operand_b; // Upper immediate already shifted
            default: next.result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            out_o <= '0;
        end else if (!stall_i) begin
            out_o <= next;
        end
    end

endmodule

// ==== src/execute_shift.sv ====
// Execute lane for shifts and set-less-than compares, registered into the retire stage
`timescale 1ns/100ps

module execute_shift (
    input  logic                    clk,
    input  logic                    rst_i,
    input  logic                    stall_i,
    input  logic                    valid_i,
    input  rs5_lite_pkg::exec_req_t req_i,
    output rs5_lite_pkg::lane_out_t out_o
);
    import rs5_lite_pkg::*;

    lane_out_t  next;
    logic [4:0] shamt;

    assign shamt = req_i.operand_b[4:0]; // Register and immediate forms alike

    always_comb begin
        next              = '0;
        next.valid        = valid_i;
        next.write_enable = valid_i && req_i.write_enable;
        next.rd           = req_i.rd;
        case (req_i.op)
            OP_SLL:  next.result = req_i.operand_a << shamt;
            OP_SRL:  next.result = req_i.operand_a >> shamt;
            OP_SRA:  next.result = $signed(req_i.operand_a) >>> shamt;
            OP_SLT:  next.result = {31'b0, $signed(req_i.operand_a) < $signed(req_i.operand_b)};
            OP_SLTU: next.result = {31'b0, req_i.operand_a < req_i.operand_b};
            default: next.result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            out_o <= '0;
        end else if (!stall_i) begin
            out_o <= next;
        end
    end

endmodule

// ==== src/execute_lsu.sv ====
// Execute lane for LW and SW: forms the address, strobe and store data for retire
`timescale 1ns/100ps

module execute_lsu (
    input  logic                    clk,
    input  logic                    rst_i,
    input  logic                    stall_i,
    input  logic                    valid_i,
    input  rs5_lite_pkg::exec_req_t req_i,
    output rs5_lite_pkg::lane_out_t out_o
);
    import rs5_lite_pkg::*;

    lane_out_t next;

    always_comb begin
        next                = '0;
        next.valid          = valid_i;
        next.rd             = req_i.rd;
        next.mem_address    = req_i.operand_a + req_i.operand_b; // Base plus offset
        next.mem_write_data = req_i.store_data;
        if (valid_i && req_i.op == OP_LW) begin
            next.mem_read     = 1'b1;
            next.write_enable = req_i.write_enable; // Retire supplies the data
        end
        if (valid_i && req_i.op == OP_SW) begin
            next.mem_strobe = WORD_STROBE;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            out_o <= '0;
        end else if (!stall_i) begin
            out_o <= next;
        end
    end

    assert property (@(posedge clk) disable iff (rst_i)
        out_o.valid |-> out_o.mem_address[1:0] == 2'b00)
        else $error("misaligned word access at %h", out_o.mem_address);

endmodule

// ==== src/retire_arbiter.sv ====
// Retire step: picks the one valid lane, drives the data memory port and register writeback
`timescale 1ns/100ps

module retire_arbiter (
    input  logic                                clk,
    input  logic                                rst_i,
    input  logic                                stall_i,
    input  rs5_lite_pkg::lane_out_t             alu_i,
    input  rs5_lite_pkg::lane_out_t             shift_i,
    input  rs5_lite_pkg::lane_out_t             lsu_i,
    input  logic [rs5_lite_pkg::XLEN-1:0]       mem_data_i,
    output logic [rs5_lite_pkg::XLEN-1:0]       mem_address_o,
    output logic [rs5_lite_pkg::XLEN-1:0]       mem_data_o,
    output logic [3:0]                          mem_write_enable_o,
    output logic                                mem_operation_enable_o,
    output logic                                wb_enable_o,
    output logic [rs5_lite_pkg::REG_ADDR_W-1:0] wb_rd_o,
    output logic [rs5_lite_pkg::XLEN-1:0]       wb_data_o
);
    import rs5_lite_pkg::*;

    lane_out_t sel;

    always_comb begin
        sel = '0; // Nothing retires
        if (alu_i.valid) begin
            sel = alu_i;
        end else if (shift_i.valid) begin
            sel = shift_i;
        end else if (lsu_i.valid) begin
            sel = lsu_i;
        end
    end

    ////////////////////////////////////////
    // Memory port, strobes masked by stall
    ////////////////////////////////////////

    assign mem_address_o          = sel.mem_address;
    assign mem_data_o             = sel.mem_write_data;
    assign mem_write_enable_o     = stall_i ? 4'b0000 : sel.mem_strobe;
    assign mem_operation_enable_o = !stall_i && (sel.mem_read || sel.mem_strobe != '0);

    ////////////////////////////////////////
    // Register writeback
    ////////////////////////////////////////

    assign wb_enable_o = !stall_i && sel.write_enable && (sel.rd != '0); // x0 stays zero
    assign wb_rd_o     = sel.rd;
    assign wb_data_o   = sel.mem_read ? mem_data_i : sel.result; // Load data arrives same cycle

    // Decode claims a single lane, so lanes never retire together
    assert property (@(posedge clk) disable iff (rst_i)
        $onehot0({alu_i.valid, shift_i.valid, lsu_i.valid}))
        else $error("more than one execute lane valid");

endmodule

// ==== src/rs5_lite.sv ====
// Top level of the RS5 lite core: fetch, decode, register bank, three lanes and retire
`timescale 1ns/100ps

module rs5_lite #(
    parameter logic [rs5_lite_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                          clk,
    input  logic                          rst_i,
    input  logic                          stall_i,
    input  logic [rs5_lite_pkg::XLEN-1:0] instruction_i,
    input  logic [rs5_lite_pkg::XLEN-1:0] mem_data_i,
    output logic [rs5_lite_pkg::XLEN-1:0] instruction_address_o,
    output logic [rs5_lite_pkg::XLEN-1:0] mem_address_o,
    output logic [rs5_lite_pkg::XLEN-1:0] mem_data_o,
    output logic                          mem_operation_enable_o,
    output logic [3:0]                    mem_write_enable_o
);
    import rs5_lite_pkg::*;

    logic                  fetch_enable;
    logic [XLEN-1:0]       instruction_decode;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic [2:0]            lane_sel;
    exec_req_t             req;
    lane_out_t             alu_out;
    lane_out_t             shift_out;
    lane_out_t             lsu_out;
    logic                  wb_enable;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic [XLEN-1:0]       wb_data;

    ////////////////////////////////////////
    // Input side
    ////////////////////////////////////////

    fetch_unit #(
        .RESET_PC              (RESET_PC)
    ) u_fetch (
        .clk                   (clk),
        .rst_i                 (rst_i),
        .enable_i              (fetch_enable),
        .instruction_i         (instruction_i),
        .instruction_address_o (instruction_address_o),
        .instruction_o         (instruction_decode)
    );

    decode_unit u_decode (
        .clk            (clk),
        .rst_i          (rst_i),
        .stall_i        (stall_i),
        .instruction_i  (instruction_decode),
        .rs1_data_i     (rs1_data),
        .rs2_data_i     (rs2_data),
        .rs1_o          (rs1),
        .rs2_o          (rs2),
        .fetch_enable_o (fetch_enable),
        .lane_sel_o     (lane_sel),
        .req_o          (req)
    );

    register_bank u_regs (
        .clk     (clk),
        .rs1_i   (rs1),
        .rs2_i   (rs2),
        .we_i    (wb_enable),
        .rd_i    (wb_rd),
        .data_i  (wb_data),
        .data1_o (rs1_data),
        .data2_o (rs2_data)
    );

    ////////////////////////////////////////
    // Execute lanes
    ////////////////////////////////////////

    execute_alu u_alu (
        .clk     (clk),
        .rst_i   (rst_i),
        .stall_i (stall_i),
        .valid_i (lane_sel[LANE_ALU]),
        .req_i   (req),
        .out_o   (alu_out)
    );

    execute_shift u_shift (
        .clk     (clk),
        .rst_i   (rst_i),
        .stall_i (stall_i),
        .valid_i (lane_sel[LANE_SHIFT]),
        .req_i   (req),
        .out_o   (shift_out)
    );

    execute_lsu u_lsu (
        .clk     (clk),
        .rst_i   (rst_i),
        .stall_i (stall_i),
        .valid_i (lane_sel[LANE_LSU]),
        .req_i   (req),
        .out_o   (lsu_out)
    );

    ////////////////////////////////////////
    // Output side
    ////////////////////////////////////////

    retire_arbiter u_retire (
        .clk                    (clk),
        .rst_i                  (rst_i),
        .stall_i                (stall_i),
        .alu_i                  (alu_out),
        .shift_i                (shift_out),
        .lsu_i                  (lsu_out),
        .mem_data_i             (mem_data_i),
        .mem_address_o          (mem_address_o),
        .mem_data_o             (mem_data_o),
        .mem_write_enable_o     (mem_write_enable_o),
        .mem_operation_enable_o (mem_operation_enable_o),
        .wb_enable_o            (wb_enable),
        .wb_rd_o                (wb_rd),
        .wb_data_o              (wb_data)
    );

endmodule

// ==== dv/tb_clock_gen.sv ====
// Testbench clock and reset source: free-running clock, reset held for a set number of cycles
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0; // Released away from the sampling edge
    end

endmodule

// ==== dv/tb_rs5_lite.sv ====
// Testbench for the RS5 lite core: runs the stimulus program, serves memory, checks every store
`timescale 1ns/100ps

module tb_rs5_lite;

    localparam int          CLK_PERIOD = 100;
    localparam logic [31:0] NOP_WORD   = 32'h0000_0013;
    localparam int          IMAGE_BASE = 64;  // Data image section of the stimulus
    localparam int          EXP_BASE   = 96;  // Expected store triples
    localparam int          COUNT_BASE = 240; // Section lengths

    logic        clk;
    logic        rst_i;
    logic        stall_i;
    logic [31:0] instruction_i;
    logic [31:0] mem_data_i;
    logic [31:0] instruction_address_o;
    logic [31:0] mem_address_o;
    logic [31:0] mem_data_o;
    logic        mem_operation_enable_o;
    logic [3:0]  mem_write_enable_o;

    logic [31:0] stim [0:255];
    logic [31:0] data_mem [0:63];
    int prog_len;
    int exp_count;
    int exp_idx;
    int errors;
    int test_errors;
    int test_stores;
    int tests_run;
    int tests_failed;
    int cur_test;

    tb_clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(16)) u_clk (
        .clk_o (clk),
        .rst_o (rst_i)
    );

    rs5_lite #(.RESET_PC(32'h0)) u_dut (
        .clk                    (clk),
        .rst_i                  (rst_i),
        .stall_i                (stall_i),
        .instruction_i          (instruction_i),
        .mem_data_i             (mem_data_i),
        .instruction_address_o  (instruction_address_o),
        .mem_address_o          (mem_address_o),
        .mem_data_o             (mem_data_o),
        .mem_operation_enable_o (mem_operation_enable_o),
        .mem_write_enable_o     (mem_write_enable_o)
    );

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        if ((addr >> 2) < prog_len) begin
            return stim[addr[7:2]];
        end
        return NOP_WORD; // Past the end of the program
    endfunction

    task automatic close_test(input int num);
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        errors += test_errors;
        $display("test %0d: %0d checks, %0d errors", num, test_stores, test_errors);
        test_errors = 0;
        test_stores = 0;
    endtask

    task automatic compare_store();
        int num;
        if (exp_idx >= exp_count) begin
            $display("Store to %h after the last expected store at %0t", mem_address_o, $time);
            errors++;
            return;
        end
        num = stim[EXP_BASE + 3 * exp_idx];
        if (mem_address_o !== stim[EXP_BASE + 3 * exp_idx + 1]) begin
            $display("FAIL %0t mem_address_o expected %h got %h", $time,
                     stim[EXP_BASE + 3 * exp_idx + 1], mem_address_o);
            test_errors++;
        end
        if (mem_data_o !== stim[EXP_BASE + 3 * exp_idx + 2]) begin
            $display("FAIL %0t mem_data_o expected %h got %h", $time,
                     stim[EXP_BASE + 3 * exp_idx + 2], mem_data_o);
            test_errors++;
        end
        if (mem_write_enable_o !== 4'hF) begin
            $display("FAIL %0t mem_write_enable_o expected f got %h", $time, mem_write_enable_o);
            test_errors++;
        end
        if (mem_operation_enable_o !== 1'b1) begin
            $display("FAIL %0t mem_operation_enable_o expected 1 got %b", $time,
                     mem_operation_enable_o);
            test_errors++;
        end
        test_stores++;
        data_mem[mem_address_o[7:2]] = mem_data_o;
        exp_idx++;
        if (exp_idx == exp_count || stim[EXP_BASE + 3 * exp_idx] != num) begin
            close_test(num);
        end
    endtask

    initial begin
        instruction_i = NOP_WORD;
        mem_data_i    = '0;
        stall_i       = 1'b0;
        errors        = 0;
        test_errors   = 0;
        test_stores   = 0;
        tests_run     = 0;
        tests_failed  = 0;
        exp_idx       = 0;
        void'($urandom(8)); // Seed for the stall pulses
        $readmemh("dv/rs5_lite_stimulus.hex", stim);
        prog_len  = stim[COUNT_BASE];
        exp_count = stim[COUNT_BASE + 1];
        if (prog_len <= 0 || exp_count <= 0) begin
            $display("Stimulus file gave no program or no expected stores");
            errors++;
        end
        for (int i = 0; i < 64; i++) begin
            data_mem[i] = 32'hDA00_0000 | (i << 2); // Unwritten words show their address
        end
        for (int i = 0; i < stim[COUNT_BASE + 2]; i++) begin
            data_mem[i] = stim[IMAGE_BASE + i];
        end

        // Reset state, checked once reset has been released
        @(negedge rst_i);
        #(CLK_PERIOD / 10);
        if (instruction_address_o !== 32'h0) begin
            $display("FAIL %0t instruction_address_o expected 0 got %h", $time,
                     instruction_address_o);
            test_errors++;
        end
        if (mem_operation_enable_o !== 1'b0) begin
            $display("FAIL %0t mem_operation_enable_o expected 0 got %b", $time,
                     mem_operation_enable_o);
            test_errors++;
        end
        if (mem_write_enable_o !== 4'h0) begin
            $display("FAIL %0t mem_write_enable_o expected 0 got %h", $time, mem_write_enable_o);
            test_errors++;
        end
        test_stores = 3;
        close_test(1);

        wait (exp_idx == exp_count);
        repeat (2) @(negedge clk);
        $display("tests %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // Drive side of the memory model and the stall pulses
    always @(negedge clk) begin
        instruction_i = fetch_word(instruction_address_o);
        mem_data_i    = data_mem[mem_address_o[7:2]]; // Load data in the same cycle
        cur_test      = (exp_idx < exp_count) ? stim[EXP_BASE + 3 * exp_idx] : 0;
        stall_i       = !rst_i && cur_test == 5 && ($urandom % 3 == 0);
    end

    always @(posedge clk) begin
        if (!rst_i) begin
            if (stall_i && mem_operation_enable_o !== 1'b0) begin
                $display("FAIL %0t mem_operation_enable_o expected 0 got %b during stall",
                         $time, mem_operation_enable_o);
                test_errors++;
            end
            if (stall_i && mem_write_enable_o !== 4'h0) begin
                $display("FAIL %0t mem_write_enable_o expected 0 got %h during stall",
                         $time, mem_write_enable_o);
                test_errors++;
            end
            if (mem_write_enable_o != 4'h0) begin
                compare_store();
            end
        end
    end

    // Watchdog sized from the program length
    initial begin
        wait (prog_len > 0);
        #((prog_len * 4 + 100 + 16) * CLK_PERIOD);
        $display("Run did not finish in %0d cycles, %0d of %0d stores seen",
                 prog_len * 4 + 100, exp_idx, exp_count);
        $display("sim failed");
        $finish;
    end

endmodule

// ==== dv/rs5_lite_stimulus.hex ====
// Word index 00: program words. 40: data image, word k at byte address 4*k
// 60: expected stores as triples of test number, address, data. F0: program, store, image counts
@00
123450B7 67808093 FFD00113 002081B3 // Test 2: lui, addi, addi, add
08302023 40208233 08402223 0020F2B3 // sw, sub, sw, and
08502423 0020E333 08602623 0020C3B3 // sw, or, sw, xor
08702823 0F00F413 08802A23          // sw, andi, sw
FF000493 00400513 00A095B3 08B02C23 // Test 3: x9=-16, x10=4, sll, sw
00A4D633 08C02E23 40A4D6B3 0AD02023 // srl, sw, sra, sw
00809713 4024D793 01C4D813 00A4A8B3 // slli, srai, srli, slt
00A4B933 FF14A993 0AE02223 0AF02423 // sltu, slti, sw, sw
0B002623 0B102823 0B202A23 0B302C23 // sw x16..x19
00700A13 005A0A13 014A0AB3 0FFACA93 // Test 4: chain through x20, x21
0D502023 00802B03 015B0BB3 0D702223 // sw, lw x22, add from load, sw
800BEC13 0D802423                   // ori, sw
12300C93 004C9D13 419D0DB3 0DB02823 // Test 5: addi, slli, sub, sw
00402E03 01BE4EB3 0DD02A23 0DC02C23 // lw, xor, sw, sw
00C02F03 0FE02023 00002F83 0FF02223 // Test 6: lw, sw, lw, sw
@40
5A5A0F0F CAFEF00D 00000100 89ABCDEF
@60
2 00000080 12345675
2 00000084 1234567B
2 00000088 12345678
2 0000008C FFFFFFFD
2 00000090 EDCBA985
2 00000094 00000070
3 00000098 23456780
3 0000009C 0FFFFFFF
3 000000A0 FFFFFFFF
3 000000A4 34567800
3 000000A8 FFFFFFFC
3 000000AC 0000000F
3 000000B0 00000001
3 000000B4 00000000
3 000000B8 00000001
4 000000C0 000000E7
4 000000C4 000001E7
4 000000C8 FFFFF9E7
5 000000D0 0000110D
5 000000D4 CAFEE100
5 000000D8 CAFEF00D
6 000000E0 89ABCDEF
6 000000E4 5A5A0F0F
@F0
00000039 00000017 00000004

// ==== flist.f ====
src/rs5_lite_pkg.sv
src/fetch_unit.sv
src/decode_unit.sv
src/register_bank.sv
src/execute_alu.sv
src/execute_shift.sv
src/execute_lsu.sv
src/retire_arbiter.sv
src/rs5_lite.sv
dv/tb_clock_gen.sv
dv/tb_rs5_lite.sv

// ==== Makefile ====
TOP := tb_rs5_lite

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^sim passed$$" sim.log

lint:
	verilator --lint-only --timing -Wall -f flist.f --top-module rs5_lite

clean:
	rm -rf obj_dir sim.log
